// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_radio_core
FLIST     ?= radio_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: ctrl_proc_fsm.sv
/*
 * Control packet processor
 * Parses header and command beats, strobes the settings bus,
 * captures the readback word and returns a two-beat response
 */

`timescale 1ns/100ps

`include "radio_core_macros.svh"

module ctrl_proc_fsm (
   input  logic                         bus_clk,
   input  logic                         i_rst,
   // Control stream in
   input  radio_core_pkg::stream_beat_t i_ctrl,
   input  logic                         i_ctrl_tvalid,
   output logic                         o_ctrl_tready,
   // Response stream out
   output radio_core_pkg::stream_beat_t o_resp,
   output logic                         o_resp_tvalid,
   input  logic                         i_resp_tready,
   // Settings bus and readback
   output radio_core_pkg::set_bus_t     o_set,
   input  radio_core_pkg::rb_word_t     i_readback
);
   import radio_core_pkg::*;

   ctrl_state_t           state;
   logic [`RC_WORD_W-1:0] hdr_q;   // Echoed as response header
   rb_word_t              rb_q;
   set_addr_t             addr_q;
   set_data_t             data_q;
   logic                  ctrl_fire;
   logic                  resp_fire;

   ////////////////////////////////////////////////////////////////////////////
   // Handshakes

   // Input only accepted while no packet is being worked on
   assign o_ctrl_tready = (state == ST_IDLE) || (state == ST_CMD);
   assign ctrl_fire     = i_ctrl_tvalid && o_ctrl_tready;

   assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
   assign resp_fire     = o_resp_tvalid && i_resp_tready;

   // Both beats come from registers, so they hold while stalled
   assign o_resp = '{
      tdata: (state == ST_RESP_DATA) ? rb_q : hdr_q,
      tlast: (state == ST_RESP_DATA)
   };

   assign o_set = '{
      stb:  (state == ST_SET),
      addr: addr_q,
      data: data_q
   };

   ////////////////////////////////////////////////////////////////////////////
   // State machine

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         state  <= ST_IDLE;
         hdr_q  <= '0;
         rb_q   <= '0;
         addr_q <= '0;
         data_q <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // A header with tlast set is a malformed packet, drop it
               if (ctrl_fire && !i_ctrl.tlast) begin
                  hdr_q <= i_ctrl.tdata;
                  state <= ST_CMD;
               end
            end
            ST_CMD: begin
               if (ctrl_fire) begin
                  addr_q <= i_ctrl.tdata[`RC_DATA_W +: `RC_ADDR_W];  // Bits 39:32
                  data_q <= i_ctrl.tdata[`RC_DATA_W-1:0];
                  state  <= ST_SET;
               end
            end
            ST_SET: begin
               state <= ST_RB;   // Write lands at end of this cycle
            end
            ST_RB: begin
               rb_q  <= i_readback;
               state <= ST_RESP_HDR;
            end
            ST_RESP_HDR: begin
               if (resp_fire) begin
                  state <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (resp_fire) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: radio_core.f
+incdir+.
radio_core_pkg.sv
ctrl_proc_fsm.sv
timekeeper.sv
radio_settings.sv
radio_frontend.sv
radio_core.sv
radio_core_assert.sv
tb_radio_core.sv

// File: radio_core.sv
/*
 * Radio control core top level
 * Control packet processor, settings, timekeeper and front end on bus_clk
 */

`timescale 1ns/100ps

module radio_core (
   input  logic                         bus_clk,
   input  logic                         i_rst,
   // Control and response streams
   input  radio_core_pkg::stream_beat_t i_ctrl,
   input  logic                         i_ctrl_tvalid,
   output logic                         o_ctrl_tready,
   output radio_core_pkg::stream_beat_t o_resp,
   output logic                         o_resp_tvalid,
   input  logic                         i_resp_tready,
   // Timing and front end
   input  logic                         i_pps,
   input  logic                         i_tx_run,
   input  radio_core_pkg::iq_sample_t   i_tx_sample,
   input  radio_core_pkg::iq_sample_t   i_rx,
   output radio_core_pkg::iq_sample_t   o_tx,
   output radio_core_pkg::iq_sample_t   o_rx_fe
);
   import radio_core_pkg::*;

   set_bus_t   set_bus;
   rb_word_t   readback;
   vita_time_t vita_time;
   vita_time_t time_lastpps;
   logic       loopback;
   iq_sample_t tx_idle;

   ctrl_proc_fsm ctrl_proc_fsm_inst (
      .bus_clk       (bus_clk),
      .i_rst         (i_rst),
      .i_ctrl        (i_ctrl),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_resp        (o_resp),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .o_set         (set_bus),
      .i_readback    (readback)
   );

   timekeeper timekeeper_inst (
      .bus_clk        (bus_clk),
      .i_rst          (i_rst),
      .i_set          (set_bus),
      .i_pps          (i_pps),
      .o_vita_time    (vita_time),
      .o_time_lastpps (time_lastpps)
   );

   // Slot 3 reads the registered TX word over the raw RX input
   radio_settings radio_settings_inst (
      .bus_clk        (bus_clk),
      .i_rst          (i_rst),
      .i_set          (set_bus),
      .i_vita_time    (vita_time),
      .i_time_lastpps (time_lastpps),
      .i_tx_word      (o_tx),
      .i_rx_word      (i_rx),
      .o_loopback     (loopback),
      .o_tx_idle      (tx_idle),
      .o_readback     (readback)
   );

   radio_frontend radio_frontend_inst (
      .bus_clk     (bus_clk),
      .i_rst       (i_rst),
      .i_tx_run    (i_tx_run),
      .i_tx_sample (i_tx_sample),
      .i_tx_idle   (tx_idle),
      .i_loopback  (loopback),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_fe     (o_rx_fe)
   );

endmodule

// File: radio_core_assert.sv
/*
 * Control processor assertions
 * Strobe width, response hold under stall, no input while responding
 */

`timescale 1ns/100ps

module radio_core_assert (
   input logic                         bus_clk,
   input logic                         i_rst,
   input radio_core_pkg::set_bus_t     o_set,
   input radio_core_pkg::stream_beat_t o_resp,
   input logic                         o_resp_tvalid,
   input logic                         i_resp_tready,
   input logic                         o_ctrl_tready
);
   import radio_core_pkg::*;

   a_stb_single: assert property (@(posedge bus_clk) disable iff (i_rst)
      o_set.stb |=> !o_set.stb)
      else $error("settings strobe high for two cycles");

   // Stalled beat must not change
   a_resp_hold: assert property (@(posedge bus_clk) disable iff (i_rst)
      o_resp_tvalid && !i_resp_tready |=> o_resp_tvalid && $stable(o_resp))
      else $error("response beat changed while stalled");

   a_no_accept: assert property (@(posedge bus_clk) disable iff (i_rst)
      o_resp_tvalid |-> !o_ctrl_tready)
      else $error("control input ready during a response");

endmodule

bind ctrl_proc_fsm radio_core_assert radio_core_assert_inst (
   .bus_clk       (bus_clk),
   .i_rst         (i_rst),
   .o_set         (o_set),
   .o_resp        (o_resp),
   .o_resp_tvalid (o_resp_tvalid),
   .i_resp_tready (i_resp_tready),
   .o_ctrl_tready (o_ctrl_tready)
);

// File: radio_core_macros.svh
/*
 * Radio control core constants
 * Settings bus addresses, readback slot numbers and bus widths
 */

`ifndef RADIO_CORE_MACROS_SVH
`define RADIO_CORE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus addresses

`define RC_SR_LOOPBACK    8'd6     // TX to RX digital loopback
`define RC_SR_TEST        8'd21
`define RC_SR_CODEC_IDLE  8'd22    // TX word when not running
`define RC_SR_READBACK    8'd32
`define RC_SR_TIME_HI     8'd128   // Held until the low half arrives
`define RC_SR_TIME_LO     8'd129

////////////////////////////////////////////////////////////////////////////
// Readback slots

`define RC_RB_TEST        3'd0
`define RC_RB_TIME        3'd1
`define RC_RB_LASTPPS     3'd2
`define RC_RB_FRONTEND    3'd3

// Widths
`define RC_ADDR_W         8
`define RC_DATA_W         32
`define RC_TIME_W         64
`define RC_WORD_W         64

`endif

// File: radio_core_pkg.sv
/*
 * Radio control core types
 * Vector typedefs, settings bus and stream beat structs, control FSM states
 */

`include "radio_core_macros.svh"

package radio_core_pkg;

   // Settings bus fields
   typedef logic [`RC_ADDR_W-1:0] set_addr_t;
   typedef logic [`RC_DATA_W-1:0] set_data_t;

   typedef struct packed {
      logic      stb;     // One cycle per write
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef logic [`RC_TIME_W-1:0] vita_time_t;

   // I in [31:16], Q in [15:0]
   typedef logic [31:0] iq_sample_t;

   typedef logic [2:0]            rb_addr_t;
   typedef logic [`RC_WORD_W-1:0] rb_word_t;

   // One beat of the control or response stream
   typedef struct packed {
      logic [`RC_WORD_W-1:0] tdata;
      logic                  tlast;
   } stream_beat_t;

   typedef enum logic [2:0] {
      ST_IDLE      = 3'd0,  // Waiting for header
      ST_CMD       = 3'd1,  // Waiting for command word
      ST_SET       = 3'd2,  // Settings strobe out
      ST_RB        = 3'd3,  // Readback captured here
      ST_RESP_HDR  = 3'd4,
      ST_RESP_DATA = 3'd5
   } ctrl_state_t;

endpackage

// File: radio_frontend.sv
/*
 * Front-end registers
 * TX output picks sample or idle word, RX side picks input or loopback
 */

`timescale 1ns/100ps

module radio_frontend (
   input  logic                       bus_clk,
   input  logic                       i_rst,
   input  logic                       i_tx_run,
   input  radio_core_pkg::iq_sample_t i_tx_sample,
   input  radio_core_pkg::iq_sample_t i_tx_idle,
   input  logic                       i_loopback,
   input  radio_core_pkg::iq_sample_t i_rx,
   output radio_core_pkg::iq_sample_t o_tx,
   output radio_core_pkg::iq_sample_t o_rx_fe
);
   import radio_core_pkg::*;

   iq_sample_t tx_q;
   iq_sample_t rx_fe_q;

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         tx_q    <= '0;
         rx_fe_q <= '0;
      end else begin
         // Idle word keeps the DAC at a known level between bursts
         tx_q    <= i_tx_run ? i_tx_sample : i_tx_idle;
         rx_fe_q <= i_loopback ? tx_q : i_rx;   // Digital loopback from TX reg
      end
   end

   assign o_tx    = tx_q;
   assign o_rx_fe = rx_fe_q;

endmodule

// File: radio_settings.sv
/*
 * Radio settings registers
 * Loopback, test, codec idle and readback select registers,
 * plus the combinational readback multiplexer
 */

`timescale 1ns/100ps

`include "radio_core_macros.svh"

module radio_settings (
   input  logic                       bus_clk,
   input  logic                       i_rst,
   input  radio_core_pkg::set_bus_t   i_set,
   input  radio_core_pkg::vita_time_t i_vita_time,
   input  radio_core_pkg::vita_time_t i_time_lastpps,
   input  radio_core_pkg::iq_sample_t i_tx_word,
   input  radio_core_pkg::iq_sample_t i_rx_word,
   output logic                       o_loopback,
   output radio_core_pkg::iq_sample_t o_tx_idle,
   output radio_core_pkg::rb_word_t   o_readback
);
   import radio_core_pkg::*;

   logic       loopback_q;
   set_data_t  test_q;     // Scratch register for host checks
   iq_sample_t idle_q;
   rb_addr_t   rb_sel_q;

   ////////////////////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         loopback_q <= 1'b0;
         test_q     <= '0;
         idle_q     <= '0;
         rb_sel_q   <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `RC_SR_LOOPBACK: begin
               loopback_q <= i_set.data[0];
            end
            `RC_SR_TEST: begin
               test_q <= i_set.data;
            end
            `RC_SR_CODEC_IDLE: begin
               idle_q <= i_set.data;
            end
            `RC_SR_READBACK: begin
               rb_sel_q <= i_set.data[$bits(rb_addr_t)-1:0];
            end
            default: begin
               // Other addresses belong to the timekeeper or are unused
            end
         endcase
      end
   end

   assign o_loopback = loopback_q;
   assign o_tx_idle  = idle_q;

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux

   // Select is registered, so a new select shows in its own response
   always_comb begin
      case (rb_sel_q)
         `RC_RB_TEST: begin
            o_readback = {{(`RC_WORD_W - `RC_DATA_W){1'b0}}, test_q};
         end
         `RC_RB_TIME: begin
            o_readback = i_vita_time;
         end
         `RC_RB_LASTPPS: begin
            o_readback = i_time_lastpps;
         end
         `RC_RB_FRONTEND: begin
            o_readback = {i_tx_word, i_rx_word};   // TX in upper half
         end
         default: begin
            o_readback = '0;   // Slots of removed logic
         end
      endcase
   end

endmodule

// File: tb_radio_core.sv
/*
 * Testbench for the radio control core
 * Sends control packets under random response back-pressure and checks
 * the readbacks, time load, PPS capture and front-end paths
 */

`timescale 1ns/100ps

`include "radio_core_macros.svh"

module tb_radio_core;
   import radio_core_pkg::*;

   localparam int N_PKTS  = 27;
   localparam int WD_CYCS = N_PKTS * 40 + 200;   // Worst case per packet plus slack

   logic         bus_clk;
   logic         rst;
   stream_beat_t ctrl;
   logic         ctrl_tvalid;
   logic         ctrl_tready;
   stream_beat_t resp;
   logic         resp_tvalid;
   logic         resp_tready = 1'b1;
   logic         pps;
   logic         tx_run;
   iq_sample_t   tx_sample;
   iq_sample_t   rx;
   iq_sample_t   tx;
   iq_sample_t   rx_fe;

   integer seed    = 32'hee3be54e;
   integer bp_seed = 32'hee3be54e;   // Own stream for the stall pattern

   // Register model
   set_data_t  m_test;
   iq_sample_t m_idle;
   rb_addr_t   m_sel;
   set_data_t  m_hi;
   logic       ref_exact;

   // Expected response for the compare process
   logic [63:0] exp_hdr;
   rb_word_t    exp_rb;
   logic        exp_chk = 1'b0;
   rb_word_t    last_rb = '0;
   int resp_cnt = 0;
   int beat_cnt = 0;
   int cmp_errs = 0;
   int cmp_checks = 0;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int err_mark = 0;

   radio_core radio_core_inst (
      .bus_clk       (bus_clk),
      .i_rst         (rst),
      .i_ctrl        (ctrl),
      .i_ctrl_tvalid (ctrl_tvalid),
      .o_ctrl_tready (ctrl_tready),
      .o_resp        (resp),
      .o_resp_tvalid (resp_tvalid),
      .i_resp_tready (resp_tready),
      .i_pps         (pps),
      .i_tx_run      (tx_run),
      .i_tx_sample   (tx_sample),
      .i_rx          (rx),
      .o_tx          (tx),
      .o_rx_fe       (rx_fe)
   );

   initial begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;
   end

   // Roughly one stalled cycle in four
   always @(negedge bus_clk) begin
      resp_tready = (($random(bp_seed) & 32'sd3) != 32'sd0);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model

   // Expected readback for a command with ref_exact low where only a range is known
   function automatic rb_word_t ref_readback(input set_addr_t addr, input set_data_t data);
      rb_word_t v;
      case (addr)
         `RC_SR_TEST:       m_test = data;
         `RC_SR_CODEC_IDLE: m_idle = data;
         `RC_SR_READBACK:   m_sel  = data[2:0];
         `RC_SR_TIME_HI:    m_hi   = data;
         default: ;
      endcase
      ref_exact = 1'b1;
      case (m_sel)
         `RC_RB_TEST:     v = {32'h0, m_test};
         `RC_RB_TIME: begin
            v         = {m_hi, data};
            ref_exact = (addr == `RC_SR_TIME_LO);   // Only a fresh load is known
         end
         `RC_RB_LASTPPS: begin
            v         = '0;
            ref_exact = 1'b0;
         end
         `RC_RB_FRONTEND: v = {(tx_run ? tx_sample : m_idle), rx};
         default:         v = '0;
      endcase
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Response compare

   always @(posedge bus_clk) begin
      if (!rst && resp_tvalid && resp_tready) begin
         beat_cnt = beat_cnt + 1;
         // No new packet may be taken while a response goes out
         cmp_checks = cmp_checks + 1;
         assert (!ctrl_tready) else begin
            $display("error: o_ctrl_tready got %h expected %h", ctrl_tready, 1'b0);
            cmp_errs = cmp_errs + 1;
         end
         if (!resp.tlast) begin
            cmp_checks = cmp_checks + 1;
            assert (resp.tdata == exp_hdr) else begin
               $display("error: o_resp.tdata header got %h expected %h", resp.tdata, exp_hdr);
               cmp_errs = cmp_errs + 1;
            end
         end else begin
            last_rb = resp.tdata;
            if (exp_chk) begin
               cmp_checks = cmp_checks + 1;
               assert (resp.tdata == exp_rb) else begin
                  $display("error: o_resp.tdata readback got %h expected %h",
                           resp.tdata, exp_rb);
                  cmp_errs = cmp_errs + 1;
               end
            end
            resp_cnt = resp_cnt + 1;
         end
      end
   end

   task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks = checks + 1;
      assert (got == exp) else begin
         $display("error: %s got %h expected %h", name, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks = checks + 1;
      assert (cond) else begin
         $display("%s", what);
         errors = errors + 1;
      end
   endtask

   // Holds the beat until it transfers
   task automatic send_beat(input logic [63:0] d, input logic last);
      ctrl        = '{tdata: d, tlast: last};
      ctrl_tvalid = 1'b1;
      do begin
         @(posedge bus_clk);
      end while (!ctrl_tready);
      @(negedge bus_clk);
      ctrl_tvalid = 1'b0;
   endtask

   task automatic send_cmd(input set_addr_t addr, input set_data_t data);
      logic [63:0] hdr;
      int target;
      hdr     = {$random(seed), $random(seed)};
      exp_hdr = hdr;
      exp_rb  = ref_readback(addr, data);
      exp_chk = ref_exact;
      target  = resp_cnt + 1;
      send_beat(hdr, 1'b0);
      send_beat({24'h0, addr, data}, 1'b1);
      wait (resp_cnt == target);
      @(negedge bus_clk);
   endtask

   task automatic finish_test(input string name);
      $display("test %-10s %0d errors", name, errors + cmp_errs - err_mark);
      err_mark = errors + cmp_errs;
      tests    = tests + 1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests

   initial begin
      rb_word_t t_load;
      rb_word_t t_pps;
      int       beats;
      rst = 1'b1;
      ctrl = '0;
      ctrl_tvalid = 1'b0;
      pps = 1'b0;
      tx_run = 1'b0;
      tx_sample = '0;
      rx = '0;
      m_test = '0;
      m_idle = '0;
      m_sel = '0;
      m_hi = '0;
      exp_hdr = '0;
      exp_rb = '0;
      repeat (2) @(posedge bus_clk);
      @(negedge bus_clk);
      rst = 1'b0;
      check_true(ctrl_tready && !resp_tvalid,
                 "control input not ready or response valid after reset");

      repeat (8) send_cmd(`RC_SR_TEST, $random(seed));
      finish_test("test_reg");

      for (int i = 4; i < 8; i++) send_cmd(`RC_SR_READBACK, i);   // Unused slots read zero
      send_cmd(`RC_SR_READBACK, `RC_RB_TEST);
      finish_test("rb_select");

      send_cmd(`RC_SR_READBACK, `RC_RB_TIME);
      send_cmd(`RC_SR_TIME_HI, $random(seed));
      send_cmd(`RC_SR_TIME_LO, $random(seed));
      t_load = exp_rb;
      send_cmd(8'd200, 32'h0);
      check_true(last_rb > t_load, "time did not advance after the load");
      finish_test("time_load");

      send_cmd(`RC_SR_TIME_HI, $random(seed));
      send_cmd(`RC_SR_TIME_LO, $random(seed));
      t_load = exp_rb;
      pps = 1'b1;
      repeat (3) @(negedge bus_clk);
      pps = 1'b0;
      send_cmd(`RC_SR_READBACK, `RC_RB_LASTPPS);
      t_pps = last_rb;
      send_cmd(`RC_SR_READBACK, `RC_RB_TIME);
      check_true(t_pps >= t_load && t_pps <= last_rb,
                 "PPS time lies outside the load and read window");
      finish_test("pps");

      send_cmd(`RC_SR_CODEC_IDLE, $random(seed));
      check_equal("o_tx", {32'h0, tx}, {32'h0, m_idle});
      tx_sample = $random(seed);
      tx_run    = 1'b1;
      rx        = $random(seed);
      @(negedge bus_clk);
      check_equal("o_tx", {32'h0, tx}, {32'h0, tx_sample});
      check_equal("o_rx_fe", {32'h0, rx_fe}, {32'h0, rx});
      send_cmd(`RC_SR_LOOPBACK, 32'h1);
      check_equal("o_rx_fe", {32'h0, rx_fe}, {32'h0, tx_sample});
      send_cmd(`RC_SR_READBACK, `RC_RB_FRONTEND);
      finish_test("frontend");

      beats = beat_cnt;
      send_beat({$random(seed), $random(seed)}, 1'b1);
      repeat (8) @(negedge bus_clk);
      check_true(beat_cnt == beats, "response sent for a discarded one-beat packet");
      send_cmd(`RC_SR_READBACK, `RC_RB_TEST);
      send_cmd(`RC_SR_TEST, $random(seed));
      finish_test("discard");

      $display("tests %0d checks %0d errors %0d", tests, checks + cmp_checks,
               errors + cmp_errs);
      if (errors + cmp_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WD_CYCS) @(posedge bus_clk);
      $display("timeout: run did not finish within %0d cycles", WD_CYCS);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: timekeeper.sv
/*
 * Time counter
 * Free-running 64-bit count, loaded in two halves over the settings bus,
 * latched on every rising PPS edge
 */

`timescale 1ns/100ps

`include "radio_core_macros.svh"

module timekeeper (
   input  logic                       bus_clk,
   input  logic                       i_rst,
   input  radio_core_pkg::set_bus_t   i_set,
   input  logic                       i_pps,
   output radio_core_pkg::vita_time_t o_vita_time,
   output radio_core_pkg::vita_time_t o_time_lastpps
);
   import radio_core_pkg::*;

   vita_time_t time_q;
   vita_time_t lastpps_q;
   set_data_t  time_hi_q;   // Upper half waiting for the low write
   logic       pps_d;
   logic       pps_rise;
   logic       load_hi;
   logic       load_lo;

   assign load_hi  = i_set.stb && (i_set.addr == `RC_SR_TIME_HI);
   assign load_lo  = i_set.stb && (i_set.addr == `RC_SR_TIME_LO);
   assign pps_rise = i_pps && !pps_d;

   ////////////////////////////////////////////////////////////////////////////
   // Counter and load

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         time_q    <= '0;
         time_hi_q <= '0;
      end else begin
         if (load_lo) begin
            time_q <= {time_hi_q, i_set.data};   // Takes effect at end of strobe
         end else begin
            time_q <= time_q + 1'b1;
         end
         if (load_hi) begin
            time_hi_q <= i_set.data;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS capture

   always_ff @(posedge bus_clk) begin
      if (i_rst) begin
         pps_d     <= 1'b0;
         lastpps_q <= '0;
      end else begin
         pps_d <= i_pps;
         if (pps_rise) begin
            lastpps_q <= time_q;   // Time seen in the edge cycle
         end
      end
   end

   assign o_vita_time    = time_q;
   assign o_time_lastpps = lastpps_q;

endmodule
